/* verilog/or1420CiPkg.sv */
`default_nettype none

package or1420CiPkg;

  // ****************************************
  // shared widths
  // ****************************************
  typedef logic [31:0] ciWord;      // operand or result.
  typedef logic [7:0]  ciNumber;    // custom instruction number.
  typedef logic [31:0] cycleCount;  // system clock cycles.

  typedef enum logic [1:0] {
    idle,
    waitTick,
    finish
  } delayState;

  // ****************************************
  // instruction numbers
  // ****************************************
  localparam ciNumber SwapByteId  = 8'd1;
  localparam ciNumber CpuFreqId   = 8'd4;
  localparam ciNumber DelayId     = 8'd6;
  localparam ciNumber GrayscaleId = 8'd9;

  // system clock edges between lock and reset release.
  localparam int ResetCycles = 16;

endpackage

`default_nettype wire

/* verilog/ciBus.sv */
`timescale 1ns/1ps
`default_nettype none

interface ciBus;
  import or1420CiPkg::*;

  logic    start;  // one cycle issue strobe.
  ciNumber nId;
  ciWord   dataA;
  ciWord   dataB;

  modport unit (
    input start,
    input nId,
    input dataA,
    input dataB
  );

endinterface

`default_nettype wire

/* verilog/resetSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset,
  output logic peripheralResetN
);
  import or1420CiPkg::*;

  localparam int CountWidth = $clog2(ResetCycles) + 1;

  logic [CountWidth-1:0] resetCount;

  // saturates once the top bit is set.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[CountWidth-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign peripheralResetN = resetCount[CountWidth-1];
  assign systemReset      = ~peripheralResetN;

  releaseHeld : assert property (@(posedge s_systemClock)
    $past(s_pllLocked) && s_pllLocked && $past(peripheralResetN) |-> peripheralResetN);

endmodule

`default_nettype wire

/* verilog/referenceTickSync.sv */
`timescale 1ns/1ps
`default_nettype none

module referenceTickSync (
  input  logic s_systemClock,
  input  logic systemReset,
  input  logic referenceClock,
  output logic refTick
);

  // ****************************************
  // synchronizer and edge detect
  // ****************************************
  logic refMeta;
  logic refSync;
  logic refLast;

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      refMeta <= 1'b0;
      refSync <= 1'b0;
      refLast <= 1'b0;
      refTick <= 1'b0;
    end else begin
      refMeta <= referenceClock;  // may go metastable.
      refSync <= refMeta;
      refLast <= refSync;
      refTick <= refSync & ~refLast;  // one pulse per rising edge.
    end
  end

endmodule

`default_nettype wire

/* verilog/swapByteCi.sv */
`timescale 1ns/1ps
`default_nettype none

module swapByteCi #(
  parameter or1420CiPkg::ciNumber CustomId = or1420CiPkg::SwapByteId
) (
  ciBus.unit                 ci,
  output logic               done,
  output or1420CiPkg::ciWord result
);
  import or1420CiPkg::*;

  ciWord swapped;

  assign done = ci.start && (ci.nId == CustomId);

  always_comb begin
    if (ci.dataB[0]) begin
      // swap within each half word.
      swapped = {ci.dataA[23:16], ci.dataA[31:24], ci.dataA[7:0], ci.dataA[15:8]};
    end else begin
      // full reversal, little to big endian.
      swapped = {ci.dataA[7:0], ci.dataA[15:8], ci.dataA[23:16], ci.dataA[31:24]};
    end
  end

  assign result = done ? swapped : '0;  // zero keeps the OR bus clean.

endmodule

`default_nettype wire

/* verilog/grayscaleCi.sv */
`timescale 1ns/1ps
`default_nettype none

module grayscaleCi #(
  parameter or1420CiPkg::ciNumber CustomId = or1420CiPkg::GrayscaleId
) (
  ciBus.unit                 ci,
  output logic               done,
  output or1420CiPkg::ciWord result
);
  import or1420CiPkg::*;

  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;
  ciWord       grayWord;

  assign done = ci.start && (ci.nId == CustomId);

  // ****************************************
  // rgb565 widened by bit replication
  // ****************************************
  assign red   = {ci.dataA[15:11], ci.dataA[15:13]};
  assign green = {ci.dataA[10:5], ci.dataA[10:9]};
  assign blue  = {ci.dataA[4:0], ci.dataA[4:2]};

  // weights add up to 256, so no overflow.
  assign weightedSum = red * 16'd54 + green * 16'd183 + blue * 16'd19;

  assign grayWord = {24'd0, weightedSum[15:8]};
  assign result   = done ? grayWord : '0;

endmodule

`default_nettype wire

/* verilog/cpuFreqCi.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuFreqCi #(
  parameter or1420CiPkg::ciNumber CustomId    = or1420CiPkg::CpuFreqId,
  parameter int                   WindowTicks = 8
) (
  input  logic               s_systemClock,
  input  logic               systemReset,
  input  logic               refTick,
  ciBus.unit                 ci,
  output logic               done,
  output or1420CiPkg::ciWord result
);
  import or1420CiPkg::*;

  localparam int TickWidth = $clog2(WindowTicks + 1);

  logic [TickWidth-1:0] tickCount;
  logic                 windowEnd;
  cycleCount            cycleCounter;
  cycleCount            latchedCount;

  assign windowEnd = refTick && (tickCount == TickWidth'(WindowTicks - 1));

  // ****************************************
  // measurement window
  // ****************************************
  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      tickCount    <= '0;
      cycleCounter <= '0;
      latchedCount <= '0;
    end else if (windowEnd) begin
      tickCount    <= '0;
      cycleCounter <= '0;
      latchedCount <= cycleCounter + 1'b1;  // this cycle counts too.
    end else begin
      cycleCounter <= cycleCounter + 1'b1;
      if (refTick) begin
        tickCount <= tickCount + 1'b1;
      end
    end
  end

  assign done   = ci.start && (ci.nId == CustomId);
  assign result = done ? latchedCount : '0;

endmodule

`default_nettype wire

/* verilog/delayCi.sv */
`timescale 1ns/1ps
`default_nettype none

module delayCi #(
  parameter or1420CiPkg::ciNumber CustomId            = or1420CiPkg::DelayId,
  parameter int                   TicksPerMicrosecond = 12
) (
  input  logic               s_systemClock,
  input  logic               systemReset,
  input  logic               refTick,
  ciBus.unit                 ci,
  output logic               done,
  output or1420CiPkg::ciWord result
);
  import or1420CiPkg::*;

  localparam int TickWidth = $clog2(TicksPerMicrosecond + 1);

  delayState            state;
  logic                 startMatch;
  logic [TickWidth-1:0] tickCount;
  ciWord                microsecondsLeft;

  assign startMatch = ci.start && (ci.nId == CustomId);

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      state            <= idle;
      tickCount        <= '0;
      microsecondsLeft <= '0;
    end else begin
      case (state)
        idle: begin
          if (startMatch) begin
            tickCount        <= '0;
            microsecondsLeft <= ci.dataA;
            state            <= (ci.dataA == '0) ? finish : waitTick;
          end
        end
        waitTick: begin
          if (refTick) begin
            if (tickCount == TickWidth'(TicksPerMicrosecond - 1)) begin
              tickCount        <= '0;
              microsecondsLeft <= microsecondsLeft - 1'b1;
              if (microsecondsLeft == ciWord'(1)) state <= finish;
            end else begin
              tickCount <= tickCount + 1'b1;
            end
          end
        end
        default: state <= idle;  // finish lasts one cycle.
      endcase
    end
  end

  assign done   = (state == finish);
  assign result = '0;

  // the core stalls on this instruction, so no overlap is possible.
  noStartWhileBusy : assert property (@(posedge s_systemClock) disable iff (systemReset)
    startMatch |-> state == idle);

endmodule

`default_nettype wire

/* verilog/or1420CiHub.sv */
`timescale 1ns/1ps
`default_nettype none

module or1420CiHub #(
  parameter or1420CiPkg::ciNumber SwapByteId  = or1420CiPkg::SwapByteId,
  parameter or1420CiPkg::ciNumber CpuFreqId   = or1420CiPkg::CpuFreqId,
  parameter or1420CiPkg::ciNumber DelayId     = or1420CiPkg::DelayId,
  parameter or1420CiPkg::ciNumber GrayscaleId = or1420CiPkg::GrayscaleId,
  parameter int FreqWindowTicks          = 8,
  parameter int DelayTicksPerMicrosecond = 12
) (
  input  logic                s_systemClock,
  input  logic                s_pllLocked,
  input  logic                referenceClock,
  input  logic                ciStart,
  input  or1420CiPkg::ciNumber ciN,
  input  or1420CiPkg::ciWord  ciDataA,
  input  or1420CiPkg::ciWord  ciDataB,
  output logic                ciDone,
  output or1420CiPkg::ciWord  ciResult,
  output logic                peripheralResetN
);
  import or1420CiPkg::*;

  logic  systemReset;
  logic  refTick;
  logic  swapByteDone, grayscaleDone, cpuFreqDone, delayDone;
  ciWord swapByteResult, grayscaleResult, cpuFreqResult, delayResult;

  // ****************************************
  // reset and reference tick
  // ****************************************
  resetSequencer resetSequencerInst (.s_systemClock, .s_pllLocked, .systemReset,
                                     .peripheralResetN);
  referenceTickSync referenceTickSyncInst (.s_systemClock, .systemReset, .referenceClock,
                                           .refTick);

  // ****************************************
  // instruction units
  // ****************************************
  ciBus ciIf ();
  assign ciIf.start = ciStart & peripheralResetN;  // starts ignored in reset.
  assign ciIf.nId   = ciN;
  assign ciIf.dataA = ciDataA;
  assign ciIf.dataB = ciDataB;

  swapByteCi #(.CustomId(SwapByteId)) swapByteInst (.ci(ciIf), .done(swapByteDone),
                                                    .result(swapByteResult));
  grayscaleCi #(.CustomId(GrayscaleId)) grayscaleInst (.ci(ciIf), .done(grayscaleDone),
                                                       .result(grayscaleResult));
  cpuFreqCi #(.CustomId(CpuFreqId), .WindowTicks(FreqWindowTicks)) cpuFreqInst (
    .s_systemClock, .systemReset, .refTick, .ci(ciIf), .done(cpuFreqDone),
    .result(cpuFreqResult));
  delayCi #(.CustomId(DelayId), .TicksPerMicrosecond(DelayTicksPerMicrosecond)) delayInst (
    .s_systemClock, .systemReset, .refTick, .ci(ciIf), .done(delayDone),
    .result(delayResult));

  // units drive zero when idle, so a plain OR merges them.
  assign ciDone   = swapByteDone | grayscaleDone | cpuFreqDone | delayDone;
  assign ciResult = swapByteResult | grayscaleResult | cpuFreqResult | delayResult;

  singleDone : assert property (@(posedge s_systemClock) disable iff (systemReset)
    $onehot0({swapByteDone, grayscaleDone, cpuFreqDone, delayDone}));

endmodule

`default_nettype wire

/* test/tbOr1420CiHub.sv */
`timescale 1ns/1ps
`default_nettype none

module tbOr1420CiHub;

  localparam int ClockPeriod   = 20;
  localparam int RefHalfPeriod = 60;  // 120 ns reference, six system cycles.
  localparam int RefCycles     = 6;
  localparam int LockCycles    = 8;
  localparam int ResetCycles   = 16;
  localparam int WindowTicks   = 8;
  localparam int CycleBudget   = 2000;
  localparam logic [7:0] SwapNumber = 8'd1;
  localparam logic [7:0] GrayNumber = 8'd9;

  logic        s_systemClock;
  logic        s_pllLocked;
  logic        referenceClock;
  logic        ciStart;
  logic [7:0]  ciN;
  logic [31:0] ciDataA;
  logic [31:0] ciDataB;
  logic        ciDone;
  logic [31:0] ciResult;
  logic        peripheralResetN;

  string       names[$];
  string       kinds[$];
  logic [7:0]  numbers[$];
  logic [31:0] operandsA[$];
  logic [31:0] operandsB[$];
  logic [31:0] expectations[$];
  int          tolerances[$];
  int          vectorCount = -1;

  or1420CiHub or1420CiHub_inst (
    .s_systemClock, .s_pllLocked, .referenceClock, .ciStart, .ciN, .ciDataA, .ciDataB,
    .ciDone, .ciResult, .peripheralResetN
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(ClockPeriod / 2) s_systemClock = ~s_systemClock;
  end

  initial begin
    referenceClock = 1'b0;
    #5;  // keeps reference edges off system edges.
    forever #(RefHalfPeriod) referenceClock = ~referenceClock;
  end

  task automatic abortRun(input string reason);
    $display("%0s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual, input int tol);
    logic [31:0] diff;
    diff = (actual > expected) ? actual - expected : expected - actual;
    assert (diff <= 32'(tol)) else
      abortRun($sformatf("FAILED %0s expected 0x%08h actual 0x%08h", name, expected, actual));
  endtask

  // destination byte per source byte.
  function automatic logic [31:0] byteSwapModel(input logic [31:0] a, input logic halves);
    logic [31:0] swapped;
    int          i;
    int          target;
    for (i = 0; i < 4; i++) begin
      target = halves ? (i ^ 1) : (3 - i);
      swapped[target*8 +: 8] = a[i*8 +: 8];
    end
    return swapped;
  endfunction

  function automatic logic [31:0] grayModel(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = pixel[15:11];
    green = pixel[10:5];
    blue  = pixel[4:0];
    red   = (red << 3) | (red >> 2);
    green = (green << 2) | (green >> 4);
    blue  = (blue << 3) | (blue >> 2);
    return (red * 54 + green * 183 + blue * 19) >> 8;
  endfunction

  task automatic loadVectors();
    int          fd;
    int          count;
    string       line;
    string       name;
    string       kind;
    logic [7:0]  n;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    int          tol;
    fd = $fopen("test/ciHubInput.txt", "r");
    if (fd == 0) abortRun("cannot open test/ciHubInput.txt");
    while ($fgets(line, fd) != 0) begin
      count = $sscanf(line, "%s %d %h %h %s %h %d", name, n, a, b, kind, expected, tol);
      if (line[0] == "#" || count <= 0) continue;
      if (count != 7) abortRun($sformatf("malformed vector line: %0s", line));
      names.push_back(name);
      numbers.push_back(n);
      operandsA.push_back(a);
      operandsB.push_back(b);
      kinds.push_back(kind);
      expectations.push_back(expected);
      tolerances.push_back(tol);
    end
    $fclose(fd);
    vectorCount = names.size();
  endtask

  // ****************************************
  // reset release, start held high throughout
  // ****************************************
  task automatic checkResetRelease();
    int edges;
    ciStart = 1'b1;
    ciN     = SwapNumber;
    repeat (LockCycles) begin
      @(negedge s_systemClock);
      assert (!peripheralResetN && !ciDone) else abortRun("reset released before lock");
    end
    s_pllLocked = 1'b1;
    for (edges = 1; edges < ResetCycles; edges++) begin
      @(negedge s_systemClock);
      assert (!peripheralResetN && !ciDone) else
        abortRun($sformatf("reset released or done seen %0d edges after lock", edges));
    end
    @(negedge s_systemClock);
    checkValue("resetRelease", 32'd1, {31'd0, peripheralResetN}, 0);
    ciStart = 1'b0;
  endtask

  // one cycle start, then wait for done or the limit.
  task automatic issueInstruction(input logic [7:0] n, input logic [31:0] a,
                                  input logic [31:0] b, input int limit,
                                  output int latency, output logic [31:0] result,
                                  output logic gotDone, output logic leaked);
    latency = 0;
    gotDone = 1'b0;
    leaked  = 1'b0;
    result  = '0;
    @(negedge s_systemClock);
    ciStart = 1'b1;
    ciN     = n;
    ciDataA = a;
    ciDataB = b;
    forever begin
      #(ClockPeriod / 4);  // clear of both edges.
      if (ciDone) begin
        gotDone = 1'b1;
        result  = ciResult;
      end else if (ciResult != '0) begin
        leaked = 1'b1;
      end
      if (gotDone || latency >= limit) break;
      @(negedge s_systemClock);
      ciStart = 1'b0;
      latency++;
    end
    @(negedge s_systemClock);
    ciStart = 1'b0;
  endtask

  initial begin
    wait (vectorCount >= 0);
    repeat (vectorCount * CycleBudget + 1000) @(posedge s_systemClock);
    abortRun($sformatf("timeout after %0d cycles", vectorCount * CycleBudget + 1000));
  end

  initial begin
    int          i;
    int          limit;
    int          latency;
    logic [31:0] result;
    logic        gotDone;
    logic        leaked;
    s_pllLocked = 1'b0;
    ciStart     = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    loadVectors();
    checkResetRelease();
    for (i = 0; i < vectorCount; i++) begin
      if (kinds[i] == "near") begin
        repeat (2 * WindowTicks * RefCycles) @(negedge s_systemClock);  // two windows.
      end else if (kinds[i] == "latency") begin
        @(posedge referenceClock);
      end
      limit = (kinds[i] == "none") ? tolerances[i] : CycleBudget;
      issueInstruction(numbers[i], operandsA[i], operandsB[i], limit, latency, result,
                       gotDone, leaked);
      assert (!leaked) else abortRun($sformatf("%0s: ciResult not zero without ciDone", names[i]));
      if (kinds[i] == "none") begin
        assert (!gotDone) else abortRun($sformatf("%0s: ciDone rose unexpectedly", names[i]));
      end else begin
        assert (gotDone) else abortRun($sformatf("%0s: no ciDone in %0d cycles", names[i], limit));
        if (kinds[i] == "latency") begin
          checkValue(names[i], expectations[i], latency, tolerances[i]);
          checkValue(names[i], 32'd0, result, 0);
        end else begin
          checkValue(names[i], expectations[i], result, tolerances[i]);
        end
        if (numbers[i] == SwapNumber)
          checkValue(names[i], byteSwapModel(operandsA[i], operandsB[i][0]), result, 0);
        if (numbers[i] == GrayNumber)
          checkValue(names[i], grayModel(operandsA[i][15:0]), result, 0);
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* test/ciHubInput.txt */
# name n(decimal) a(hex) b(hex) kind expected(hex) tol(decimal)
# exact and near check the result, latency checks done cycles, none waits tol cycles for no done
swapReverse       1 12345678 00000000 exact   78563412 0
swapHalves        1 12345678 00000001 exact   34127856 0
swapReverseBeef   1 deadbeef 00000000 exact   efbeadde 0
swapHalvesBeef    1 deadbeef 00000001 exact   addeefbe 0
grayRed           9 0000f800 00000000 exact   00000035 0
grayGreen         9 000007e0 00000000 exact   000000b6 0
grayBlue          9 0000001f 00000000 exact   00000012 0
grayWhite         9 0000ffff 00000000 exact   000000ff 0
grayBlack         9 00000000 00000000 exact   00000000 0
grayUpperIgnored  9 abcd8410 00000000 exact   00000082 0
freqWindow        4 00000000 00000000 near    00000030 1
delayThree        6 00000003 00000000 latency 000000d8 4
delayZero         6 00000000 00000000 latency 00000001 2
unknownTwenty    20 12345678 00000000 none    00000000 10

/* or1420CiHub.f */
verilog/or1420CiPkg.sv
verilog/ciBus.sv
verilog/resetSequencer.sv
verilog/referenceTickSync.sv
verilog/swapByteCi.sv
verilog/grayscaleCi.sv
verilog/cpuFreqCi.sv
verilog/delayCi.sv
verilog/or1420CiHub.sv
test/tbOr1420CiHub.sv

/* Makefile */
TB_TOP := tbOr1420CiHub

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module or1420CiHub -f or1420CiHub.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB_TOP) \
	  -f or1420CiHub.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
